// ==== source/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // register-register layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // register-immediate layout, shifts keep shamt in imm12[4:0]
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // branch offset is scattered over the rd and funct7 slots
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    u_fmt_t u;
    b_fmt_t b;
  } insn_word_u;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

  // alu funct3
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SRL  = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam int OP_W = 5;

  localparam logic [OP_W-1:0] OP_NONE  = 5'd0;
  localparam logic [OP_W-1:0] OP_LUI   = 5'd1;
  localparam logic [OP_W-1:0] OP_ADD   = 5'd2;
  localparam logic [OP_W-1:0] OP_SUB   = 5'd3;
  localparam logic [OP_W-1:0] OP_SLT   = 5'd4;
  localparam logic [OP_W-1:0] OP_SLTU  = 5'd5;
  localparam logic [OP_W-1:0] OP_XOR   = 5'd6;
  localparam logic [OP_W-1:0] OP_OR    = 5'd7;
  localparam logic [OP_W-1:0] OP_AND   = 5'd8;
  localparam logic [OP_W-1:0] OP_SLL   = 5'd9;
  localparam logic [OP_W-1:0] OP_SRL   = 5'd10;
  localparam logic [OP_W-1:0] OP_SRA   = 5'd11;
  localparam logic [OP_W-1:0] OP_BEQ   = 5'd12;
  localparam logic [OP_W-1:0] OP_BNE   = 5'd13;
  localparam logic [OP_W-1:0] OP_BLT   = 5'd14;
  localparam logic [OP_W-1:0] OP_BGE   = 5'd15;
  localparam logic [OP_W-1:0] OP_BLTU  = 5'd16;
  localparam logic [OP_W-1:0] OP_BGEU  = 5'd17;
  localparam logic [OP_W-1:0] OP_ECALL = 5'd18;

endpackage

// ==== source/pipe_pkg.sv ====
package pipe_pkg;

  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;

  // one-hot status of the cycle seen in writeback
  localparam int STATUS_W = 6;

  localparam logic [STATUS_W-1:0] CYCLE_RESET        = 6'd1;
  localparam logic [STATUS_W-1:0] CYCLE_NO_STALL     = 6'd2;
  localparam logic [STATUS_W-1:0] CYCLE_TAKEN_BRANCH = 6'd4;

  // operand source chosen for the execute stage
  localparam int BYP_W = 2;

  localparam logic [BYP_W-1:0] BYP_RF  = 2'd0;
  localparam logic [BYP_W-1:0] BYP_MEM = 2'd1;
  localparam logic [BYP_W-1:0] BYP_WB  = 2'd2;

endpackage

// ==== source/insn_decoder.sv ====
module insn_decoder (
  input  rv_isa_pkg::insn_word_u                insn,
  output logic [rv_isa_pkg::OP_W-1:0]           op,
  output logic                                  use_imm,
  output logic [pipe_pkg::REG_IDX_W-1:0]        rs1,
  output logic [pipe_pkg::REG_IDX_W-1:0]        rs2,
  output logic [pipe_pkg::REG_IDX_W-1:0]        rd,
  output logic                                  rd_we,
  output logic [pipe_pkg::XLEN-1:0]             imm
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  logic [REG_IDX_W-1:0] rd_field;
  logic                 writes_rd;

  always_comb begin
    op       = OP_NONE;
    use_imm  = 1'b0;
    rs1      = '0;
    rs2      = '0;
    rd_field = '0;
    imm      = '0;
    case (insn.r.opcode)
      OPC_LUI: begin
        op       = OP_LUI;
        rd_field = insn.u.rd;
        imm      = {insn.u.imm20, 12'b0};
      end
      OPC_OP_IMM: begin
        use_imm  = 1'b1;
        rs1      = insn.i.rs1;
        rd_field = insn.i.rd;
        imm      = {{20{insn.i.imm12[11]}}, insn.i.imm12};
        case (insn.i.funct3)
          F3_ADD:  op = OP_ADD;
          F3_SLT:  op = OP_SLT;
          F3_SLTU: op = OP_SLTU;
          F3_XOR:  op = OP_XOR;
          F3_OR:   op = OP_OR;
          F3_AND:  op = OP_AND;
          F3_SLL:  op = (insn.r.funct7 == FUNCT7_BASE) ? OP_SLL : OP_NONE;
          F3_SRL: begin
            if (insn.r.funct7 == FUNCT7_BASE) op = OP_SRL;
            else if (insn.r.funct7 == FUNCT7_ALT) op = OP_SRA;
          end
          default: op = OP_NONE;
        endcase
        // shifts take only the shamt field
        if (insn.i.funct3 == F3_SLL || insn.i.funct3 == F3_SRL) begin
          imm = {27'b0, insn.i.imm12[4:0]};
        end
      end
      OPC_OP: begin
        rs1      = insn.r.rs1;
        rs2      = insn.r.rs2;
        rd_field = insn.r.rd;
        if (insn.r.funct7 == FUNCT7_BASE) begin
          case (insn.r.funct3)
            F3_ADD:  op = OP_ADD;
            F3_SLL:  op = OP_SLL;
            F3_SLT:  op = OP_SLT;
            F3_SLTU: op = OP_SLTU;
            F3_XOR:  op = OP_XOR;
            F3_SRL:  op = OP_SRL;
            F3_OR:   op = OP_OR;
            default: op = OP_AND;
          endcase
        end else if (insn.r.funct7 == FUNCT7_ALT) begin
          if (insn.r.funct3 == F3_ADD) op = OP_SUB;
          else if (insn.r.funct3 == F3_SRL) op = OP_SRA;
        end
      end
      OPC_BRANCH: begin
        rs1 = insn.b.rs1;
        rs2 = insn.b.rs2;
        imm = {{19{insn.b.imm12}}, insn.b.imm12, insn.b.imm11, insn.b.imm10_5,
               insn.b.imm4_1, 1'b0};
        case (insn.b.funct3)
          F3_BEQ:  op = OP_BEQ;
          F3_BNE:  op = OP_BNE;
          F3_BLT:  op = OP_BLT;
          F3_BGE:  op = OP_BGE;
          F3_BLTU: op = OP_BLTU;
          F3_BGEU: op = OP_BGEU;
          default: op = OP_NONE;
        endcase
      end
      OPC_SYSTEM: begin
        // only the all-zero encoding above the opcode is ecall
        if (insn.u.imm20 == '0 && insn.u.rd == '0) op = OP_ECALL;
      end
      default: op = OP_NONE;
    endcase
  end

  assign writes_rd = op inside {OP_LUI, OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_XOR,
                                OP_OR, OP_AND, OP_SLL, OP_SRL, OP_SRA};
  assign rd_we     = writes_rd && (rd_field != '0);
  assign rd        = rd_we ? rd_field : '0;

endmodule

// ==== source/reg_file.sv ====
module reg_file (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [pipe_pkg::REG_IDX_W-1:0] rs1,
  input  logic [pipe_pkg::REG_IDX_W-1:0] rs2,
  output logic [pipe_pkg::XLEN-1:0]      rs1_data,
  output logic [pipe_pkg::XLEN-1:0]      rs2_data,
  input  logic [pipe_pkg::REG_IDX_W-1:0] rd,
  input  logic [pipe_pkg::XLEN-1:0]      rd_data,
  input  logic                           we
);
  import pipe_pkg::*;

  // x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

// ==== source/exec_unit.sv ====
module exec_unit (
  input  logic [rv_isa_pkg::OP_W-1:0] op,
  input  logic                        use_imm,
  input  logic [pipe_pkg::XLEN-1:0]   imm,
  input  logic [pipe_pkg::XLEN-1:0]   pc,
  input  logic [pipe_pkg::XLEN-1:0]   rf_rs1_data,
  input  logic [pipe_pkg::XLEN-1:0]   rf_rs2_data,
  input  logic [pipe_pkg::XLEN-1:0]   m_rd_data,
  input  logic [pipe_pkg::XLEN-1:0]   w_rd_data,
  input  logic [pipe_pkg::BYP_W-1:0]  bypass_rs1_sel,
  input  logic [pipe_pkg::BYP_W-1:0]  bypass_rs2_sel,
  output logic [pipe_pkg::XLEN-1:0]   result,
  output logic                        branch_taken,
  output logic [pipe_pkg::XLEN-1:0]   branch_target
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] op_b;
  logic [4:0]      shamt;

  function automatic logic [XLEN-1:0] pick_operand(
    input logic [BYP_W-1:0] sel,
    input logic [XLEN-1:0]  rf_val,
    input logic [XLEN-1:0]  m_val,
    input logic [XLEN-1:0]  w_val
  );
    case (sel)
      BYP_MEM: return m_val;
      BYP_WB:  return w_val;
      default: return rf_val;
    endcase
  endfunction

  assign rs1_val = pick_operand(bypass_rs1_sel, rf_rs1_data, m_rd_data, w_rd_data);
  assign rs2_val = pick_operand(bypass_rs2_sel, rf_rs2_data, m_rd_data, w_rd_data);

  // immediate forms replace the second register operand
  assign op_b  = use_imm ? imm : rs2_val;
  assign shamt = op_b[4:0];

  always_comb begin
    result = '0;
    case (op)
      OP_LUI:  result = imm;
      OP_ADD:  result = rs1_val + op_b;
      OP_SUB:  result = rs1_val - op_b;
      OP_SLT:  result = {{(XLEN-1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
      OP_SLTU: result = {{(XLEN-1){1'b0}}, rs1_val < op_b};
      OP_XOR:  result = rs1_val ^ op_b;
      OP_OR:   result = rs1_val | op_b;
      OP_AND:  result = rs1_val & op_b;
      OP_SLL:  result = rs1_val << shamt;
      OP_SRL:  result = rs1_val >> shamt;
      OP_SRA:  result = $signed(rs1_val) >>> shamt;
      default: result = '0;
    endcase
  end

  // branches always compare two registers
  always_comb begin
    case (op)
      OP_BEQ:  branch_taken = (rs1_val == rs2_val);
      OP_BNE:  branch_taken = (rs1_val != rs2_val);
      OP_BLT:  branch_taken = ($signed(rs1_val) < $signed(rs2_val));
      OP_BGE:  branch_taken = ($signed(rs1_val) >= $signed(rs2_val));
      OP_BLTU: branch_taken = (rs1_val < rs2_val);
      OP_BGEU: branch_taken = (rs1_val >= rs2_val);
      default: branch_taken = 1'b0;
    endcase
  end

  assign branch_target = pc + imm;

endmodule

// ==== source/pipe_control.sv ====
module pipe_control #(
  parameter logic [pipe_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           branch_taken,
  input  logic [pipe_pkg::XLEN-1:0]      branch_target,
  input  logic [pipe_pkg::REG_IDX_W-1:0] x_rs1,
  input  logic [pipe_pkg::REG_IDX_W-1:0] x_rs2,
  input  logic [pipe_pkg::REG_IDX_W-1:0] m_rd,
  input  logic                           m_we,
  input  logic [pipe_pkg::REG_IDX_W-1:0] w_rd,
  input  logic                           w_we,
  output logic [pipe_pkg::XLEN-1:0]      fetch_pc,
  output logic                           flush,
  output logic [pipe_pkg::BYP_W-1:0]     bypass_rs1_sel,
  output logic [pipe_pkg::BYP_W-1:0]     bypass_rs2_sel,
  output logic [pipe_pkg::STATUS_W-1:0]  fetch_status
);
  import pipe_pkg::*;

  logic [XLEN-1:0] pc;
  logic            m_fwd_ok;
  logic            w_fwd_ok;

  // memory stage result is younger, so it wins over writeback
  function automatic logic [BYP_W-1:0] bypass_for(
    input logic [REG_IDX_W-1:0] src,
    input logic [REG_IDX_W-1:0] m_dst,
    input logic                 m_ok,
    input logic [REG_IDX_W-1:0] w_dst,
    input logic                 w_ok
  );
    if (m_ok && src == m_dst) begin
      return BYP_MEM;
    end else if (w_ok && src == w_dst) begin
      return BYP_WB;
    end
    return BYP_RF;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (branch_taken) begin
      pc <= branch_target;
    end else begin
      pc <= pc + 32'd4;
    end
  end

  assign fetch_pc = pc;

  // fetch and decode hold wrong-path instructions once a branch resolves taken
  assign flush        = branch_taken;
  assign fetch_status = flush ? CYCLE_TAKEN_BRANCH : CYCLE_NO_STALL;

  // x0 results are never forwarded
  assign m_fwd_ok = m_we && (m_rd != '0);
  assign w_fwd_ok = w_we && (w_rd != '0);

  assign bypass_rs1_sel = bypass_for(x_rs1, m_rd, m_fwd_ok, w_rd, w_fwd_ok);
  assign bypass_rs2_sel = bypass_for(x_rs2, m_rd, m_fwd_ok, w_rd, w_fwd_ok);

endmodule

// ==== source/rv_pipeline.sv ====
module rv_pipeline #(
  parameter logic [pipe_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                           clk,
  input  logic                           rst,
  output logic [pipe_pkg::XLEN-1:0]      pc_to_imem,
  input  logic [pipe_pkg::XLEN-1:0]      insn_from_imem,
  output logic                           halt,
  output logic [pipe_pkg::XLEN-1:0]      trace_writeback_pc,
  output logic [pipe_pkg::XLEN-1:0]      trace_writeback_insn,
  output logic [pipe_pkg::STATUS_W-1:0]  trace_writeback_status,
  output logic                           trace_writeback_we,
  output logic [pipe_pkg::REG_IDX_W-1:0] trace_writeback_rd,
  output logic [pipe_pkg::XLEN-1:0]      trace_writeback_rd_data
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  logic [XLEN-1:0]      fetch_pc;
  logic [STATUS_W-1:0]  fetch_status;
  logic                 flush;
  logic [BYP_W-1:0]     bypass_rs1_sel;
  logic [BYP_W-1:0]     bypass_rs2_sel;

  // decode stage
  logic [XLEN-1:0]      d_pc;
  insn_word_u           d_insn;
  logic [STATUS_W-1:0]  d_status;
  logic [OP_W-1:0]      d_op;
  logic                 d_use_imm;
  logic [REG_IDX_W-1:0] d_rs1;
  logic [REG_IDX_W-1:0] d_rs2;
  logic [REG_IDX_W-1:0] d_rd;
  logic                 d_rd_we;
  logic [XLEN-1:0]      d_imm;

  // execute stage
  logic [XLEN-1:0]      x_pc;
  logic [XLEN-1:0]      x_insn;
  logic [STATUS_W-1:0]  x_status;
  logic [OP_W-1:0]      x_op;
  logic                 x_use_imm;
  logic [REG_IDX_W-1:0] x_rs1;
  logic [REG_IDX_W-1:0] x_rs2;
  logic [REG_IDX_W-1:0] x_rd;
  logic                 x_rd_we;
  logic [XLEN-1:0]      x_imm;
  logic [XLEN-1:0]      x_rs1_data;
  logic [XLEN-1:0]      x_rs2_data;
  logic [XLEN-1:0]      x_result;
  logic                 branch_taken;
  logic [XLEN-1:0]      branch_target;

  // memory and writeback stages
  logic [XLEN-1:0]      m_pc;
  logic [XLEN-1:0]      m_insn;
  logic [STATUS_W-1:0]  m_status;
  logic [REG_IDX_W-1:0] m_rd;
  logic                 m_we;
  logic                 m_ecall;
  logic [XLEN-1:0]      m_rd_data;
  logic [XLEN-1:0]      w_pc;
  logic [XLEN-1:0]      w_insn;
  logic [STATUS_W-1:0]  w_status;
  logic [REG_IDX_W-1:0] w_rd;
  logic                 w_we;
  logic                 w_ecall;
  logic [XLEN-1:0]      w_rd_data;

  pipe_control #(.RESET_PC(RESET_PC)) u_pipe_control (
    .clk(clk), .rst(rst),
    .branch_taken(branch_taken), .branch_target(branch_target),
    .x_rs1(x_rs1), .x_rs2(x_rs2),
    .m_rd(m_rd), .m_we(m_we), .w_rd(w_rd), .w_we(w_we),
    .fetch_pc(fetch_pc), .flush(flush),
    .bypass_rs1_sel(bypass_rs1_sel), .bypass_rs2_sel(bypass_rs2_sel),
    .fetch_status(fetch_status)
  );

  assign pc_to_imem = fetch_pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      d_pc     <= '0;
      d_insn   <= '0;
      d_status <= CYCLE_RESET;
    end else begin
      // a flushed fetch enters as an empty slot
      d_pc     <= flush ? '0 : fetch_pc;
      d_insn   <= flush ? '0 : insn_from_imem;
      d_status <= fetch_status;
    end
  end

  insn_decoder u_insn_decoder (
    .insn(d_insn), .op(d_op), .use_imm(d_use_imm),
    .rs1(d_rs1), .rs2(d_rs2), .rd(d_rd), .rd_we(d_rd_we), .imm(d_imm)
  );

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      x_pc      <= '0;
      x_insn    <= '0;
      x_status  <= rst ? CYCLE_RESET : CYCLE_TAKEN_BRANCH;
      x_op      <= OP_NONE;
      x_use_imm <= 1'b0;
      x_rs1     <= '0;
      x_rs2     <= '0;
      x_rd      <= '0;
      x_rd_we   <= 1'b0;
    end else begin
      x_pc      <= d_pc;
      x_insn    <= d_insn;
      x_status  <= d_status;
      x_op      <= d_op;
      x_use_imm <= d_use_imm;
      x_rs1     <= d_rs1;
      x_rs2     <= d_rs2;
      x_rd      <= d_rd;
      x_rd_we   <= d_rd_we;
    end
  end

  always_ff @(posedge clk) begin
    x_imm <= d_imm;
  end

  reg_file u_reg_file (
    .clk(clk), .rst(rst),
    .rs1(x_rs1), .rs2(x_rs2), .rs1_data(x_rs1_data), .rs2_data(x_rs2_data),
    .rd(w_rd), .rd_data(w_rd_data), .we(w_we)
  );

  exec_unit u_exec_unit (
    .op(x_op), .use_imm(x_use_imm), .imm(x_imm), .pc(x_pc),
    .rf_rs1_data(x_rs1_data), .rf_rs2_data(x_rs2_data),
    .m_rd_data(m_rd_data), .w_rd_data(w_rd_data),
    .bypass_rs1_sel(bypass_rs1_sel), .bypass_rs2_sel(bypass_rs2_sel),
    .result(x_result), .branch_taken(branch_taken), .branch_target(branch_target)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      m_pc     <= '0;
      m_insn   <= '0;
      m_status <= CYCLE_RESET;
      m_rd     <= '0;
      m_we     <= 1'b0;
      m_ecall  <= 1'b0;
      w_pc     <= '0;
      w_insn   <= '0;
      w_status <= CYCLE_RESET;
      w_rd     <= '0;
      w_we     <= 1'b0;
      w_ecall  <= 1'b0;
    end else begin
      m_pc     <= x_pc;
      m_insn   <= x_insn;
      m_status <= x_status;
      m_rd     <= x_rd;
      m_we     <= x_rd_we;
      m_ecall  <= (x_op == OP_ECALL);
      w_pc     <= m_pc;
      w_insn   <= m_insn;
      w_status <= m_status;
      w_rd     <= m_rd;
      w_we     <= m_we;
      w_ecall  <= m_ecall;
    end
  end

  always_ff @(posedge clk) begin
    m_rd_data <= x_result;
    w_rd_data <= m_rd_data;
  end

  assign halt                    = w_ecall;
  assign trace_writeback_pc      = w_pc;
  assign trace_writeback_insn    = w_insn;
  assign trace_writeback_status  = w_status;
  assign trace_writeback_we      = w_we;
  assign trace_writeback_rd      = w_rd;
  assign trace_writeback_rd_data = w_rd_data;

endmodule

// ==== tests/rv_pipeline_asserts.sv ====
module rv_pipeline_asserts (
  input logic                           clk,
  input logic                           rst,
  input logic                           branch_taken,
  input logic                           flush,
  input logic [pipe_pkg::XLEN-1:0]      fetch_pc,
  input logic [pipe_pkg::REG_IDX_W-1:0] m_rd,
  input logic [pipe_pkg::REG_IDX_W-1:0] w_rd,
  input logic [pipe_pkg::BYP_W-1:0]     bypass_rs1_sel,
  input logic [pipe_pkg::BYP_W-1:0]     bypass_rs2_sel
);
  import pipe_pkg::*;

  flush_needs_branch: assert property (
    @(posedge clk) disable iff (rst) flush |-> branch_taken
  ) else $error("flush raised with no taken branch");

  // sequential fetch whenever execute resolves no taken branch
  pc_steps_by_four: assert property (
    @(posedge clk) disable iff (rst) !branch_taken |=> fetch_pc == $past(fetch_pc) + 32'd4
  ) else $error("fetch pc did not advance by four");

  mem_bypass_has_rd: assert property (
    @(posedge clk) disable iff (rst)
      (bypass_rs1_sel == BYP_MEM || bypass_rs2_sel == BYP_MEM) |-> m_rd != '0
  ) else $error("memory stage bypass selected with rd x0");

  wb_bypass_has_rd: assert property (
    @(posedge clk) disable iff (rst)
      (bypass_rs1_sel == BYP_WB || bypass_rs2_sel == BYP_WB) |-> w_rd != '0
  ) else $error("writeback stage bypass selected with rd x0");

endmodule

bind pipe_control rv_pipeline_asserts u_rv_pipeline_asserts (
  .clk(clk), .rst(rst), .branch_taken(branch_taken), .flush(flush),
  .fetch_pc(fetch_pc), .m_rd(m_rd), .w_rd(w_rd),
  .bypass_rs1_sel(bypass_rs1_sel), .bypass_rs2_sel(bypass_rs2_sel)
);

// ==== tests/rv_pipeline_tb.sv ====
module rv_pipeline_tb;
  import pipe_pkg::*;

  localparam logic [XLEN-1:0] BOOT_PC  = 32'h0000_0080;
  localparam int              MAX_ROWS = 96;
  localparam logic [31:0]     NOP_WORD = 32'h0000_0013;

  logic                 clk = 1'b0;
  logic                 rst;
  logic [XLEN-1:0]      pc_to_imem;
  logic [XLEN-1:0]      insn_from_imem;
  logic                 halt;
  logic [XLEN-1:0]      trace_writeback_pc;
  logic [XLEN-1:0]      trace_writeback_insn;
  logic [STATUS_W-1:0]  trace_writeback_status;
  logic                 trace_writeback_we;
  logic [REG_IDX_W-1:0] trace_writeback_rd;
  logic [XLEN-1:0]      trace_writeback_rd_data;

  logic [31:0] imem  [256];
  logic [31:0] model [32];
  logic [31:0] next_pc;

  // expected writeback trace, one row per cycle after reset
  string               row_name   [MAX_ROWS];
  logic [XLEN-1:0]     row_pc     [MAX_ROWS];
  logic [XLEN-1:0]     row_insn   [MAX_ROWS];
  logic [STATUS_W-1:0] row_status [MAX_ROWS];
  logic                row_we     [MAX_ROWS];
  logic [4:0]          row_rd     [MAX_ROWS];
  logic [XLEN-1:0]     row_data   [MAX_ROWS];
  logic                row_halt   [MAX_ROWS];
  int                  n_rows;
  int                  n_fail;
  logic                row_ok;
  logic                table_ready = 1'b0;

  always #4 clk = ~clk;

  // instruction memory answers in the same cycle
  assign insn_from_imem = imem[pc_to_imem[9:2]];

  rv_pipeline #(.RESET_PC(BOOT_PC)) u_rv_pipeline (
    .clk(clk), .rst(rst),
    .pc_to_imem(pc_to_imem), .insn_from_imem(insn_from_imem), .halt(halt),
    .trace_writeback_pc(trace_writeback_pc), .trace_writeback_insn(trace_writeback_insn),
    .trace_writeback_status(trace_writeback_status), .trace_writeback_we(trace_writeback_we),
    .trace_writeback_rd(trace_writeback_rd), .trace_writeback_rd_data(trace_writeback_rd_data)
  );

  function automatic logic [31:0] alu_expect(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000: alu_expect = alt ? a - b : a + b;
      3'b001: alu_expect = a << b[4:0];
      3'b010: alu_expect = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: alu_expect = (a < b) ? 32'd1 : 32'd0;
      3'b100: alu_expect = a ^ b;
      3'b101: begin
        if (alt) begin
          alu_expect = $signed(a) >>> b[4:0];
        end else begin
          alu_expect = a >> b[4:0];
        end
      end
      3'b110: alu_expect = a | b;
      default: alu_expect = a & b;
    endcase
  endfunction

  function automatic logic branch_expect(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
    case (f3)
      3'b000: branch_expect = (a == b);
      3'b001: branch_expect = (a != b);
      3'b100: branch_expect = ($signed(a) < $signed(b));
      3'b101: branch_expect = ($signed(a) >= $signed(b));
      3'b110: branch_expect = (a < b);
      default: branch_expect = (a >= b);
    endcase
  endfunction

  task automatic add_row(input string name, input logic [31:0] pc, input logic [31:0] insn,
                         input logic [STATUS_W-1:0] status, input logic we,
                         input logic [4:0] rd, input logic [31:0] data, input logic hlt);
    row_name[n_rows]   = name;
    row_pc[n_rows]     = pc;
    row_insn[n_rows]   = insn;
    row_status[n_rows] = status;
    row_we[n_rows]     = we;
    row_rd[n_rows]     = rd;
    row_data[n_rows]   = data;
    row_halt[n_rows]   = hlt;
    n_rows++;
  endtask

  task automatic issue(input string name, input logic [31:0] word, input logic [4:0] rd,
                       input logic [31:0] data, input logic hlt);
    imem[next_pc[9:2]] = word;
    add_row(name, next_pc, word, CYCLE_NO_STALL, rd != 5'd0, rd, data, hlt);
    next_pc = next_pc + 32'd4;
  endtask

  task automatic imm_op(input string name, input logic [2:0] f3, input logic [6:0] f7,
                        input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    logic [11:0] field;
    logic [31:0] val;
    field = imm;
    // shifts carry funct7 above the shift amount
    if (f3 == 3'b001 || f3 == 3'b101) begin
      field = {f7, imm[4:0]};
    end
    val = alu_expect(f3, f3 == 3'b101 && f7[5], model[rs1], {{20{field[11]}}, field});
    if (rd != 5'd0) begin
      model[rd] = val;
    end
    issue(name, {field, rs1, f3, rd, 7'b0010011}, rd, (rd != 5'd0) ? val : 32'd0, 1'b0);
  endtask

  task automatic reg_op(input string name, input logic [2:0] f3, input logic [6:0] f7,
                        input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    logic [31:0] val;
    val = alu_expect(f3, f7[5], model[rs1], model[rs2]);
    if (rd != 5'd0) begin
      model[rd] = val;
    end
    issue(name, {f7, rs2, rs1, f3, rd, 7'b0110011}, rd, (rd != 5'd0) ? val : 32'd0, 1'b0);
  endtask

  task automatic lui_op(input string name, input logic [4:0] rd, input logic [19:0] upper);
    model[rd] = {upper, 12'b0};
    issue(name, {upper, rd, 7'b0110111}, rd, {upper, 12'b0}, 1'b0);
  endtask

  task automatic load_const(input string name, input logic [4:0] rd, input logic [31:0] value);
    logic [19:0] upper;
    // addi sign-extends its immediate, so round the upper part up when bit 11 is set
    upper = value[31:12] + {19'b0, value[11]};
    lui_op({name, "_lui"}, rd, upper);
    imm_op({name, "_addi"}, 3'b000, 7'd0, rd, rd, value[11:0]);
  endtask

  task automatic cond_branch(input string name, input logic [2:0] f3, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [12:0] off);
    logic [31:0] target;
    logic        taken;
    target = next_pc + {19'b0, off};
    taken  = branch_expect(f3, model[rs1], model[rs2]);
    issue(name, {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011},
          5'd0, 32'd0, 1'b0);
    if (taken) begin
      // wrong-path slots write x31, a leak past the flush shows in the trace
      while (next_pc != target) begin
        imem[next_pc[9:2]] = {12'hfff, 5'd0, 3'b000, 5'd31, 7'b0010011};
        next_pc = next_pc + 32'd4;
      end
      add_row({name, "_kill_d"}, 32'd0, 32'd0, CYCLE_TAKEN_BRANCH, 1'b0, 5'd0, 32'd0, 1'b0);
      add_row({name, "_kill_f"}, 32'd0, 32'd0, CYCLE_TAKEN_BRANCH, 1'b0, 5'd0, 32'd0, 1'b0);
    end
  endtask

  task automatic report_mismatch(input string name, input string field,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("ERROR %s: %s expected %h actual %h", name, field, exp, act);
    row_ok = 1'b0;
  endtask

  task automatic check_row(input int i);
    row_ok = 1'b1;
    if (trace_writeback_pc !== row_pc[i])
      report_mismatch(row_name[i], "pc", row_pc[i], trace_writeback_pc);
    if (trace_writeback_insn !== row_insn[i])
      report_mismatch(row_name[i], "insn", row_insn[i], trace_writeback_insn);
    if (trace_writeback_status !== row_status[i])
      report_mismatch(row_name[i], "status", 32'(row_status[i]), 32'(trace_writeback_status));
    if (trace_writeback_we !== row_we[i])
      report_mismatch(row_name[i], "we", 32'(row_we[i]), 32'(trace_writeback_we));
    if (trace_writeback_rd !== row_rd[i])
      report_mismatch(row_name[i], "rd", 32'(row_rd[i]), 32'(trace_writeback_rd));
    if (row_we[i] && trace_writeback_rd_data !== row_data[i])
      report_mismatch(row_name[i], "rd_data", row_data[i], trace_writeback_rd_data);
    if (halt !== row_halt[i])
      report_mismatch(row_name[i], "halt", 32'(row_halt[i]), 32'(halt));
    if (row_ok) begin
      $display("[%0d] %s ok", i, row_name[i]);
    end else begin
      $display("[%0d] %s failed", i, row_name[i]);
      n_fail++;
    end
  endtask

  initial begin
    logic [31:0] ra;
    logic [31:0] rb;
    logic [31:0] rc;
    logic [11:0] imm_a;
    logic [11:0] imm_b;
    logic [4:0]  sh;
    logic [19:0] upper;
    rst    = 1'b1;
    n_rows = 0;
    n_fail = 0;
    void'($urandom(97));
    for (int a = 0; a < 256; a++) begin
      imem[a] = NOP_WORD;
    end
    for (int r = 0; r < 32; r++) begin
      model[r] = 32'd0;
    end
    next_pc = BOOT_PC;
    // x1 stays non-negative and x2 negative so signed and unsigned orders differ
    ra    = $urandom & 32'h7fff_ffff;
    rb    = $urandom | 32'h8000_0000;
    // shift amounts stay nonzero so logical and arithmetic shifts of x2 differ
    rc    = $urandom | 32'd1;
    imm_a = 12'($urandom);
    imm_b = 12'($urandom) | 12'h800;
    sh    = 5'($urandom) | 5'd1;
    upper = 20'($urandom);

    for (int r = 0; r < 4; r++) begin
      add_row("reset", 32'd0, 32'd0, CYCLE_RESET, 1'b0, 5'd0, 32'd0, 1'b0);
    end
    load_const("ld_a", 5'd1, ra);
    load_const("ld_b", 5'd2, rb);
    load_const("ld_c", 5'd3, rc);
    lui_op("lui", 5'd9, upper);
    imm_op("addi", 3'b000, 7'd0, 5'd10, 5'd1, imm_a);
    imm_op("slti", 3'b010, 7'd0, 5'd11, 5'd2, imm_b);
    imm_op("sltiu", 3'b011, 7'd0, 5'd12, 5'd2, imm_b);
    imm_op("xori", 3'b100, 7'd0, 5'd13, 5'd1, imm_b);
    imm_op("ori", 3'b110, 7'd0, 5'd14, 5'd2, imm_a);
    imm_op("andi", 3'b111, 7'd0, 5'd15, 5'd1, imm_b);
    imm_op("slli", 3'b001, 7'h00, 5'd16, 5'd1, {7'd0, sh});
    imm_op("srli", 3'b101, 7'h00, 5'd17, 5'd2, {7'd0, sh});
    imm_op("srai", 3'b101, 7'h20, 5'd18, 5'd2, {7'd0, sh});
    reg_op("add", 3'b000, 7'h00, 5'd19, 5'd1, 5'd2);
    reg_op("sub", 3'b000, 7'h20, 5'd20, 5'd1, 5'd2);
    reg_op("sll", 3'b001, 7'h00, 5'd24, 5'd1, 5'd3);
    reg_op("slt", 3'b010, 7'h00, 5'd25, 5'd2, 5'd1);
    reg_op("sltu", 3'b011, 7'h00, 5'd26, 5'd2, 5'd1);
    reg_op("xor", 3'b100, 7'h00, 5'd27, 5'd1, 5'd3);
    reg_op("srl", 3'b101, 7'h00, 5'd28, 5'd2, 5'd3);
    reg_op("sra", 3'b101, 7'h20, 5'd29, 5'd2, 5'd3);
    reg_op("or", 3'b110, 7'h00, 5'd30, 5'd1, 5'd2);
    reg_op("and", 3'b111, 7'h00, 5'd4, 5'd2, 5'd3);
    // results one and two instructions old reach execute through the bypass
    imm_op("fwd_base", 3'b000, 7'd0, 5'd5, 5'd1, 12'h123);
    imm_op("fwd_mem", 3'b000, 7'd0, 5'd6, 5'd5, 12'h001);
    reg_op("fwd_both", 3'b000, 7'h00, 5'd7, 5'd5, 5'd6);
    reg_op("fwd_rs2", 3'b000, 7'h20, 5'd8, 5'd2, 5'd7);
    // memory and writeback both hold x8 here, the memory stage value is newer
    imm_op("fwd_redef", 3'b000, 7'd0, 5'd8, 5'd7, 12'h055);
    imm_op("fwd_newest", 3'b000, 7'd0, 5'd9, 5'd8, 12'h000);
    imm_op("x0_write", 3'b000, 7'd0, 5'd0, 5'd1, 12'h7ff);
    reg_op("x0_read", 3'b000, 7'h00, 5'd21, 5'd0, 5'd0);
    reg_op("x0_src2", 3'b100, 7'h00, 5'd22, 5'd1, 5'd0);
    imm_op("eq_copy", 3'b000, 7'd0, 5'd23, 5'd1, 12'h000);
    cond_branch("beq_taken", 3'b000, 5'd1, 5'd23, 13'd12);
    cond_branch("bne_not_taken", 3'b001, 5'd1, 5'd23, 13'd12);
    cond_branch("bne_taken", 3'b001, 5'd1, 5'd2, 13'd16);
    cond_branch("blt_taken", 3'b100, 5'd2, 5'd1, 13'd12);
    cond_branch("blt_not_taken", 3'b100, 5'd1, 5'd2, 13'd12);
    cond_branch("bge_taken", 3'b101, 5'd1, 5'd2, 13'd12);
    cond_branch("bge_not_taken", 3'b101, 5'd2, 5'd1, 13'd16);
    cond_branch("bltu_taken", 3'b110, 5'd1, 5'd2, 13'd12);
    cond_branch("bltu_not_taken", 3'b110, 5'd2, 5'd1, 13'd12);
    cond_branch("bgeu_taken", 3'b111, 5'd2, 5'd1, 13'd16);
    cond_branch("bgeu_equal_taken", 3'b111, 5'd1, 5'd23, 13'd12);
    cond_branch("beq_not_taken", 3'b000, 5'd1, 5'd2, 13'd12);
    imm_op("after_branches", 3'b000, 7'd0, 5'd31, 5'd23, 12'h010);
    issue("ecall", 32'h0000_0073, 5'd0, 32'd0, 1'b1);
    for (int r = 0; r < 3; r++) begin
      imm_op("nop_after_halt", 3'b000, 7'd0, 5'd0, 5'd0, 12'h000);
    end
    table_ready = 1'b1;

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      check_row(i);
      @(negedge clk);
    end
    $display("rows checked %0d, failed %0d", n_rows, n_fail);
    if (n_fail == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // bound to the table length once it is built
  initial begin
    wait (table_ready);
    #((n_rows + 20) * 8);
    $display("watchdog expired before the writeback trace was fully checked");
    $display("Errors found");
    $finish;
  end

endmodule

// ==== rv_pipeline.f ====
source/rv_isa_pkg.sv
source/pipe_pkg.sv
source/insn_decoder.sv
source/reg_file.sv
source/exec_unit.sv
source/pipe_control.sv
source/rv_pipeline.sv
tests/rv_pipeline_asserts.sv
tests/rv_pipeline_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rv_pipeline_tb \
  -f rv_pipeline.f --Mdir obj_dir -o rv_pipeline_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/rv_pipeline_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^No errors$" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1
